// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - common/memPkg.sv
  - memCtrl/memCtrl.sv
  - rtl/byteRam.sv
  - rtl/memSubsystem.sv
  - target: test
    files:
      - verification/memSubsystem_assertions.sv
      - verification/memSubsystemTb.sv

// File: common/memPkg.sv
`default_nettype none

package memPkg;

    // controller FSM state
    typedef enum logic [1:0] {
        IDLE,
        INST_READ,
        DATA_READ,
        DATA_WRITE
    } ctrlState_e;

    // data port operation
    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } memOp_e;

    // bytes moved per access
    typedef enum logic [2:0] {
        LEN_BYTE = 3'd1,
        LEN_HALF = 3'd2,
        LEN_WORD = 3'd4
    } accessLen_e;

    // data port request, held by the requester until done
    typedef struct packed {
        memOp_e     op;
        accessLen_e len;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dataReq_t;

    // one byte cycle toward the RAM
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [7:0]  wdata;
    } ramPort_t;

endpackage

`default_nettype wire

// File: memCtrl/memCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module memCtrl (
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic              i_ioBufferFull,

    // instruction fetch port
    input  wire logic              i_instReq,
    input  wire logic [31:0]       i_instAddr,
    output logic                   o_instDone,
    output logic [31:0]            o_inst,

    // data port
    input  wire logic              i_dataReq,
    input  wire memPkg::dataReq_t  i_dataCmd,
    output logic                   o_dataDone,
    output logic [31:0]            o_dataRdata,

    // byte RAM
    output memPkg::ramPort_t       o_ram,
    input  wire logic [7:0]        i_ramRdata
);

    memPkg::ctrlState_e state;
    memPkg::dataReq_t   req;

    // byte cycle within the current access, 0 to 4
    logic [2:0] stage;

    // bytes 0..2 of a read, collected as they come back
    logic [2:0][7:0] asmBytes;

    logic [3:0][7:0] writeBytes;
    logic [2:0]      addrOffset;
    logic [31:0]     wordResult;
    logic            advance;
    logic            finalStage;

    // the whole controller freezes while the I/O buffer is full
    assign advance = !i_ioBufferFull;

    assign writeBytes = req.wdata;

    always_comb begin
        case (state)
            memPkg::INST_READ,
            memPkg::DATA_READ: begin
                // read data of the last byte arrives one stage late
                finalStage = (stage == req.len);
            end
            memPkg::DATA_WRITE: begin
                finalStage = (stage == req.len - 3'd1);
            end
            default: begin
                finalStage = 1'b0;
            end
        endcase
    end

    // while stalled, keep re-reading the previous stage's byte so that
    // the RAM output still holds it when the stall drops
    always_comb begin
        if (!advance && stage != 3'd0) begin
            addrOffset = stage - 3'd1;
        end else begin
            addrOffset = stage;
        end
    end

    always_comb begin
        o_ram.we    = (state == memPkg::DATA_WRITE) && advance;
        o_ram.addr  = req.addr + {29'd0, addrOffset};
        o_ram.wdata = writeBytes[stage[1:0]];
    end

    // last byte goes straight from the RAM on top of the assembled ones
    assign wordResult = {i_ramRdata, asmBytes};

    always_comb begin
        case (req.len)
            memPkg::LEN_BYTE: begin
                o_dataRdata = {24'd0, i_ramRdata};
            end
            memPkg::LEN_HALF: begin
                o_dataRdata = {16'd0, i_ramRdata, asmBytes[0]};
            end
            default: begin
                o_dataRdata = wordResult;
            end
        endcase
    end

    assign o_inst = wordResult;

    assign o_instDone = advance && finalStage && (state == memPkg::INST_READ);

    assign o_dataDone = advance && finalStage &&
                        (state == memPkg::DATA_READ || state == memPkg::DATA_WRITE);

    // FSM and stage counter
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::IDLE;
            stage <= 3'd0;
        end else if (advance) begin
            case (state)
                memPkg::IDLE: begin
                    stage <= 3'd0;
                    // data port wins a tie
                    if (i_dataReq) begin
                        if (i_dataCmd.op == memPkg::OP_STORE) begin
                            state <= memPkg::DATA_WRITE;
                        end else begin
                            state <= memPkg::DATA_READ;
                        end
                    end else if (i_instReq) begin
                        state <= memPkg::INST_READ;
                    end
                end
                default: begin
                    if (finalStage) begin
                        state <= memPkg::IDLE;
                        stage <= 3'd0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    // latched request and read assembly
    always_ff @(posedge clk) begin
        if (advance) begin
            if (state == memPkg::IDLE) begin
                if (i_dataReq) begin
                    req <= i_dataCmd;
                end else if (i_instReq) begin
                    req <= '{
                        op:    memPkg::OP_LOAD,
                        len:   memPkg::LEN_WORD,
                        addr:  i_instAddr,
                        wdata: 32'd0
                    };
                end
            end else if (state != memPkg::DATA_WRITE) begin
                // stages 1..3 see bytes 0..2 of the access
                if (stage != 3'd0 && stage < 3'd4) begin
                    asmBytes[stage[1:0] - 2'd1] <= i_ramRdata;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: memSubsystem.f
common/memPkg.sv
memCtrl/memCtrl.sv
rtl/byteRam.sv
rtl/memSubsystem.sv
verification/memSubsystem_assertions.sv
verification/memSubsystemTb.sv

// File: rtl/byteRam.sv
`timescale 1ns/1ps
`default_nettype none

module byteRam #(
    parameter int ADDR_WIDTH = 12
) (
    input  wire logic             clk,
    input  wire memPkg::ramPort_t i_ram,
    output logic [7:0]            o_rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [7:0] mem [DEPTH];

    // upper address bits are ignored
    logic [ADDR_WIDTH-1:0] ramIdx;

    assign ramIdx = i_ram.addr[ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (i_ram.we) begin
            mem[ramIdx] <= i_ram.wdata;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        o_rdata <= mem[ramIdx];
    end

endmodule

`default_nettype wire

// File: rtl/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem #(
    parameter int ADDR_WIDTH = 12
) (
    input  wire logic             clk,
    input  wire logic             rst,

    input  wire logic             i_ioBufferFull,

    // instruction fetch port
    input  wire logic             i_instReq,
    input  wire logic [31:0]      i_instAddr,
    output logic                  o_instDone,
    output logic [31:0]           o_inst,

    // data port
    input  wire logic             i_dataReq,
    input  wire memPkg::dataReq_t i_dataCmd,
    output logic                  o_dataDone,
    output logic [31:0]           o_dataRdata
);

    memPkg::ramPort_t ram;
    logic [7:0]       ramRdata;

    memCtrl u_memCtrl (
        .clk            (clk),
        .rst            (rst),
        .i_ioBufferFull (i_ioBufferFull),
        .i_instReq      (i_instReq),
        .i_instAddr     (i_instAddr),
        .o_instDone     (o_instDone),
        .o_inst         (o_inst),
        .i_dataReq      (i_dataReq),
        .i_dataCmd      (i_dataCmd),
        .o_dataDone     (o_dataDone),
        .o_dataRdata    (o_dataRdata),
        .o_ram          (ram),
        .i_ramRdata     (ramRdata)
    );

    byteRam #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_byteRam (
        .clk     (clk),
        .i_ram   (ram),
        .o_rdata (ramRdata)
    );

endmodule

`default_nettype wire

// File: verification/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;

    localparam int ADDR_WIDTH = 12;
    localparam int ADDR_MASK = (2 ** ADDR_WIDTH) - 1;
    localparam int TIMEOUT = 40;
    localparam logic [31:0] SEED = 32'h48ebc0d9;

    logic             clk = 1'b0;
    logic             rst;
    logic             ioBufferFull;
    logic             instReq;
    logic [31:0]      instAddr;
    logic             instDone;
    logic [31:0]      inst;
    logic             dataReq;
    memPkg::dataReq_t dataCmd;
    logic             dataDone;
    logic [31:0]      dataRdata;

    // reference copy of the byte RAM
    logic [7:0] model [2 ** ADDR_WIDTH];

    int errors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int errorsAtStart = 0;

    memSubsystem #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) DUT (
        .clk            (clk),
        .rst            (rst),
        .i_ioBufferFull (ioBufferFull),
        .i_instReq      (instReq),
        .i_instAddr     (instAddr),
        .o_instDone     (instDone),
        .o_inst         (inst),
        .i_dataReq      (dataReq),
        .i_dataCmd      (dataCmd),
        .o_dataDone     (dataDone),
        .o_dataRdata    (dataRdata)
    );

    bind memSubsystem memSubsystemAssertions u_assertions (
        .clk            (clk),
        .rst            (rst),
        .i_ioBufferFull (i_ioBufferFull),
        .i_instReq      (i_instReq),
        .i_dataReq      (i_dataReq),
        .o_instDone     (o_instDone),
        .o_dataDone     (o_dataDone),
        .state          (u_memCtrl.state)
    );

    always #2 clk = ~clk;

    function automatic int totalErrors();
        return errors + DUT.u_assertions.failCount;
    endfunction

    function automatic logic [31:0] randomWordAddr();
        return ($urandom() % ((ADDR_MASK + 1) / 4)) * 4;
    endfunction

    // little-endian, zero-extended
    function automatic logic [31:0] modelRead(input logic [31:0] addr, input int len);
        logic [31:0] value;
        value = 32'd0;
        for (int k = 0; k < len; k++) begin
            value[8*k +: 8] = model[(addr + k) & ADDR_MASK];
        end
        return value;
    endfunction

    function automatic void modelWrite(input logic [31:0] addr, input int len,
                                       input logic [31:0] wdata);
        for (int k = 0; k < len; k++) begin
            model[(addr + k) & ADDR_MASK] = wdata[8*k +: 8];
        end
    endfunction

    function automatic void checkValue(input string name, input logic [31:0] expected,
                                       input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endfunction

    function automatic void startTest();
        errorsAtStart = totalErrors();
    endfunction

    function automatic void finishTest(input string name);
        testsRun++;
        if (totalErrors() == errorsAtStart) begin
            $display("test %0d %s: pass", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: fail", testsRun, name);
        end
    endfunction

    // one request on one port, optionally stalled for stallLen cycles
    // starting in cycle stallAt after accept
    task automatic runAccess(
        input  bit               isInst,
        input  memPkg::dataReq_t cmd,
        input  int               stallAt,
        input  int               stallLen,
        output logic [31:0]      result,
        output int               latency
    );
        bit seen;
        int stallLeft;
        seen = 1'b0;
        stallLeft = 0;
        result = 32'd0;
        if (isInst) begin
            instAddr = cmd.addr;
            instReq = 1'b1;
        end else begin
            dataCmd = cmd;
            dataReq = 1'b1;
        end
        // accept edge
        @(posedge clk);
        latency = 1;
        while (!seen && latency <= TIMEOUT) begin
            @(negedge clk);
            if (ioBufferFull) begin
                stallLeft--;
                if (stallLeft == 0) begin
                    ioBufferFull = 1'b0;
                end
            end else if (isInst ? instDone : dataDone) begin
                seen = 1'b1;
                result = isInst ? inst : dataRdata;
            end else if (latency == stallAt && stallLen > 0) begin
                ioBufferFull = 1'b1;
                stallLeft = stallLen;
            end
            if (!seen) begin
                @(posedge clk);
                latency++;
            end
        end
        if (!seen) begin
            @(negedge clk);
            $display("timeout at %0t: no done from the %s port within %0d cycles",
                     $time, isInst ? "instruction" : "data", TIMEOUT);
            errors++;
        end
        instReq = 1'b0;
        dataReq = 1'b0;
        ioBufferFull = 1'b0;
        // back in IDLE one cycle after done
        @(negedge clk);
    endtask

    task automatic dataOp(
        input memPkg::memOp_e     op,
        input memPkg::accessLen_e len,
        input logic [31:0]        addr,
        input logic [31:0]        wdata,
        input int                 stallAt,
        input int                 stallLen
    );
        memPkg::dataReq_t cmd;
        logic [31:0]      result;
        int               latency;
        int               n;
        n = int'(len);
        cmd = '{op: op, len: len, addr: addr, wdata: wdata};
        runAccess(1'b0, cmd, stallAt, stallLen, result, latency);
        if (op == memPkg::OP_STORE) begin
            modelWrite(addr, n, wdata);
            checkValue("store latency", n + stallLen, latency);
        end else begin
            checkValue("o_dataRdata", modelRead(addr, n), result);
            checkValue("load latency", n + 1 + stallLen, latency);
        end
    endtask

    task automatic fetch(input logic [31:0] addr);
        memPkg::dataReq_t cmd;
        logic [31:0]      result;
        int               latency;
        cmd = '{op: memPkg::OP_LOAD, len: memPkg::LEN_WORD, addr: addr, wdata: 32'd0};
        runAccess(1'b1, cmd, 0, 0, result, latency);
        checkValue("o_inst", modelRead(addr, 4), result);
        checkValue("fetch latency", 5, latency);
    endtask

    // both ports ask in the same idle cycle
    task automatic raceBothPorts(input logic [31:0] dAddr, input logic [31:0] iAddr);
        int cycle;
        int dataAt;
        int instAt;
        dataCmd = '{op: memPkg::OP_LOAD, len: memPkg::LEN_WORD, addr: dAddr, wdata: 32'd0};
        instAddr = iAddr;
        dataReq = 1'b1;
        instReq = 1'b1;
        cycle = 0;
        dataAt = 0;
        instAt = 0;
        while ((dataAt == 0 || instAt == 0) && cycle < 2 * TIMEOUT) begin
            @(posedge clk);
            cycle++;
            @(negedge clk);
            if (dataDone) begin
                dataAt = cycle;
                dataReq = 1'b0;
                checkValue("o_dataRdata", modelRead(dAddr, 4), dataRdata);
            end
            if (instDone) begin
                instAt = cycle;
                instReq = 1'b0;
                checkValue("o_inst", modelRead(iAddr, 4), inst);
            end
        end
        if (dataAt == 0 || instAt == 0) begin
            $display("timeout at %0t: both ports did not finish within %0d cycles",
                     $time, 2 * TIMEOUT);
            errors++;
        end else if (dataAt >= instAt) begin
            $display("priority error at %0t: data done in cycle %0d, instruction in cycle %0d",
                     $time, dataAt, instAt);
            errors++;
        end else begin
            checkValue("data latency", 5, dataAt);
        end
        dataReq = 1'b0;
        instReq = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        logic [31:0] addrs [4];
        logic [31:0] addr;
        int          stallLen;
        void'($urandom(SEED));
        rst = 1'b1;
        ioBufferFull = 1'b0;
        instReq = 1'b0;
        instAddr = 32'd0;
        dataReq = 1'b0;
        dataCmd = '0;

        startTest();
        repeat (8) begin
            @(negedge clk);
            checkValue("o_instDone", 32'd0, instDone);
            checkValue("o_dataDone", 32'd0, dataDone);
        end
        rst = 1'b0;
        @(negedge clk);
        checkValue("o_instDone", 32'd0, instDone);
        checkValue("o_dataDone", 32'd0, dataDone);
        finishTest("reset quiet");

        startTest();
        for (int i = 0; i < 4; i++) begin
            addrs[i] = randomWordAddr();
            dataOp(memPkg::OP_STORE, memPkg::LEN_WORD, addrs[i], $urandom(), 0, 0);
        end
        for (int i = 0; i < 4; i++) begin
            dataOp(memPkg::OP_LOAD, memPkg::LEN_WORD, addrs[i], 32'd0, 0, 0);
            dataOp(memPkg::OP_LOAD, memPkg::LEN_BYTE, addrs[i] + ($urandom() % 4), 32'd0, 0, 0);
            dataOp(memPkg::OP_LOAD, memPkg::LEN_HALF, addrs[i] + ($urandom() % 3), 32'd0, 0, 0);
        end
        finishTest("store then load");

        startTest();
        fetch(addrs[0]);
        fetch(addrs[3]);
        finishTest("instruction fetch");

        startTest();
        raceBothPorts(addrs[1], addrs[2]);
        finishTest("data port priority");

        startTest();
        addr = randomWordAddr();
        stallLen = 1 + ($urandom() % 6);
        dataOp(memPkg::OP_STORE, memPkg::LEN_WORD, addr, $urandom(), 2, stallLen);
        stallLen = 1 + ($urandom() % 6);
        dataOp(memPkg::OP_LOAD, memPkg::LEN_WORD, addr, 32'd0, 3, stallLen);
        dataOp(memPkg::OP_LOAD, memPkg::LEN_HALF, addr + 2, 32'd0, 0, 0);
        dataOp(memPkg::OP_LOAD, memPkg::LEN_BYTE, addr + 1, 32'd0, 0, 0);
        dataOp(memPkg::OP_LOAD, memPkg::LEN_WORD, addrs[0], 32'd0, 0, 0);
        finishTest("stall");

        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 testsRun, testsFailed, errors, DUT.u_assertions.failCount);
        if (totalErrors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/memSubsystem_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemAssertions (
    input wire logic               clk,
    input wire logic               rst,
    input wire logic               i_ioBufferFull,
    input wire logic               i_instReq,
    input wire logic               i_dataReq,
    input wire logic               o_instDone,
    input wire logic               o_dataDone,
    input wire memPkg::ctrlState_e state
);

    int failCount = 0;

    logic instAccept;

    // instruction request taken only when data port is quiet
    assign instAccept = (state == memPkg::IDLE) && !i_ioBufferFull && i_instReq && !i_dataReq;

    oneDoneAtATime: assert property (@(posedge clk) disable iff (rst)
        !(o_instDone && o_dataDone))
    else begin
        $error("instruction and data done outputs high in the same cycle");
        failCount++;
    end

    // a stalled edge leaves the FSM where it was
    quietWhileStalled: assert property (@(posedge clk) disable iff (rst)
        i_ioBufferFull |-> (!o_instDone && !o_dataDone) ##1 $stable(state))
    else begin
        $error("done output high or state changed while the I/O buffer is full");
        failCount++;
    end

    quietAfterReset: assert property (@(posedge clk)
        rst |=> !o_instDone && !o_dataDone)
    else begin
        $error("done output high in the cycle after reset");
        failCount++;
    end

    // accept, then four byte cycles, done in the fifth
    fetchLatency: assert property (@(posedge clk) disable iff (rst)
        instAccept ##1 (!i_ioBufferFull) [*5] |-> o_instDone)
    else begin
        $error("instruction done not seen 5 cycles after accept");
        failCount++;
    end

endmodule

`default_nettype wire
